// ==== hdl/iCachePkg.sv ====
// ################################################
// Types and constants shared by the instruction
// cache RTL and its testbench, imported by each
// ################################################

package iCachePkg;

  // One instruction, also the width of a bus data beat
  typedef logic [31:0] instrWord;

  // Word position inside a cache line
  typedef logic [1:0] wordOffset;

  // Words held per line, fetched one per bus beat
  localparam int LINE_WORDS = 4;

  // Controller FSM
  // READY      lookup, hit served combinationally
  // MEMREAD    refill in progress, one word per busReady
  // NEXTINSTR  one cycle to serve the refilled word
  typedef enum logic [1:0] {
    READY     = 2'd0,
    MEMREAD   = 2'd1,
    NEXTINSTR = 2'd2
  } ctrlState;

endpackage

// ==== hdl/cacheWayIf.sv ====
// ################################################
// Connection between the cache controller and one
// way, with a controller side and a storage side
// ################################################

`timescale 1ns/1ps

interface cacheWayIf #(
  parameter int tagBits = 14,
  parameter int setBits = 4
);
  import iCachePkg::*;

  // Lookup address, shared by read and write
  logic [setBits-1:0] setIndex;
  wordOffset          readOffset;

  // Refill write port
  logic               writeEn;
  wordOffset          writeOffset;
  logic [tagBits-1:0] writeTag;
  instrWord           writeData;

  // Way contents at setIndex
  logic [tagBits-1:0] storedTag;
  logic               valid;
  instrWord           readData;

  modport ctrl (
    output setIndex, readOffset, writeEn, writeOffset, writeTag, writeData,
    input  storedTag, valid, readData
  );

  modport way (
    input  setIndex, readOffset, writeEn, writeOffset, writeTag, writeData,
    output storedTag, valid, readData
  );

endinterface

// ==== hdl/iCacheWay.sv ====
// ################################################
// One way of the instruction cache with a tag, a
// valid bit and a four-word line per set
// ################################################

`timescale 1ns/1ps

module iCacheWay #(
  parameter int tagBits = 14,
  parameter int setBits = 4
) (
  input logic    clk,
  input logic    reset,
  cacheWayIf.way bus
);
  import iCachePkg::*;

  localparam int numSets = 1 << setBits;

  // Storage arrays
  logic [tagBits-1:0] tagMem [numSets];
  instrWord           lineMem [numSets][LINE_WORDS];
  logic [numSets-1:0] validBits;

  // Valid bits cleared on reset
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      validBits <= '0;
    end else if (bus.writeEn) begin
      validBits[bus.setIndex] <= 1'b1;
    end
  end

  // Tag and one data word stored on each refill beat
  always_ff @(posedge clk) begin
    if (bus.writeEn) begin
      tagMem[bus.setIndex]                   <= bus.writeTag;
      lineMem[bus.setIndex][bus.writeOffset] <= bus.writeData;
    end
  end

  // Combinational lookup
  assign bus.storedTag = tagMem[bus.setIndex];
  assign bus.valid     = validBits[bus.setIndex];
  assign bus.readData  = lineMem[bus.setIndex][bus.readOffset];

  // Word position must be resolved before data lands in the line
  assert property (
    @(posedge clk) disable iff (reset)
    bus.writeEn |-> !$isunknown(bus.writeOffset)
  ) else $error("iCacheWay: write offset unknown while writing");

endmodule

// ==== hdl/iCacheLru.sv ====
// ################################################
// One LRU bit per set, names the replacement victim
// A set bit means way 1 is the next victim
// ################################################

`timescale 1ns/1ps

module iCacheLru #(
  parameter int setBits = 4
) (
  input  logic               clk,
  input  logic               reset,
  input  logic [setBits-1:0] setIndex,
  input  logic               lruUpdate,
  input  logic               usedWay1,
  output logic               currLru
);

  localparam int numSets = 1 << setBits;

  logic [numSets-1:0] lruBits;

  // Point the set at the way that was not just used
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      lruBits <= '0;
    end else if (lruUpdate) begin
      lruBits[setIndex] <= ~usedWay1;
    end
  end

  assign currLru = lruBits[setIndex];

endmodule

// ==== hdl/iCacheController.sv ====
// ################################################
// Cache controller: hit check, refill FSM, bus word
// counter and way write selection
// ################################################

`timescale 1ns/1ps

module iCacheController #(
  parameter int tagBits = 14
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                enable,
  input  logic                paReady,
  input  logic                busReady,
  input  logic                currLru,
  input  logic [tagBits-1:0]  physTag,
  input  iCachePkg::wordOffset physOffset,
  cacheWayIf.ctrl             way1,
  cacheWayIf.ctrl             way2,
  output iCachePkg::wordOffset counter,
  output logic                waySel,
  output logic                iStall,
  output logic                hRequest,
  output logic                lruUpdate
);
  import iCachePkg::*;

  ctrlState           state;
  ctrlState           nextState;
  logic [tagBits-1:0] lastTag;
  logic [tagBits-1:0] tag;
  logic               way1Hit;
  logic               way2Hit;
  logic               hit;
  logic               missReq;
  logic               lastWord;
  logic               cacheWrite;
  logic               clearCounter;
  logic               writeWay1;
  logic               selWay1;
  wordOffset          counterReg;

  // Remember the tag of the last presented fetch
  always_ff @(posedge clk) begin
    if (paReady) begin
      lastTag <= physTag;
    end
  end

  assign tag = paReady ? physTag : lastTag;

  // Tag compare against both ways
  assign way1Hit = way1.valid & (tag == way1.storedTag);
  assign way2Hit = way2.valid & (tag == way2.storedTag);
  // disabled cache never hits on lookup
  assign hit     = enable & (way1Hit | way2Hit);

  // Way 1 carries the output when disabled
  assign waySel = (enable & way1Hit) | ~enable;

  assign missReq  = (state == READY) & paReady & ~hit;
  assign lastWord = busReady & ((counterReg == wordOffset'(LINE_WORDS - 1)) | ~enable);

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= READY;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      READY: begin
        if (missReq) begin
          nextState = lastWord ? NEXTINSTR : MEMREAD;
        end
      end
      MEMREAD: begin
        if (lastWord) begin
          nextState = NEXTINSTR;
        end
      end
      NEXTINSTR: nextState = READY;
      default:   nextState = READY;
    endcase
  end

  // Stall and bus request for the whole refill
  assign iStall     = (state == MEMREAD) | missReq;
  assign hRequest   = (state == MEMREAD) | missReq;
  assign cacheWrite = ((state == MEMREAD) | missReq) & busReady;

  // Hits and completed refills both count as a use
  assign lruUpdate = ((state == READY) & paReady & hit) | ((state == NEXTINSTR) & enable);

  // Bus word counter, idle at zero between refills
  assign clearCounter = (state == NEXTINSTR) | ((state == READY) & ~missReq);

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      counterReg <= '0;
    end else if (clearCounter) begin
      counterReg <= '0;
    end else if (busReady) begin
      counterReg <= counterReg + 1'b1;
    end
  end

  // Single-word fetch uses the requested offset
  assign counter = enable ? counterReg : physOffset;

  // Victim choice, kept stable once the refill has started
  always_comb begin
    writeWay1 = ((~way1.valid & way2.valid) | currLru) & ~way2Hit;
    selWay1   = writeWay1 | way1Hit | ~enable;
  end

  assign way1.writeEn     = selWay1 & cacheWrite;
  assign way2.writeEn     = ~selWay1 & cacheWrite;
  assign way1.writeOffset = counter;
  assign way2.writeOffset = counter;
  assign way1.writeTag    = tag;
  assign way2.writeTag    = tag;

  // Requested word except while the line is filling
  assign way1.readOffset = (state == MEMREAD) ? counter : physOffset;
  assign way2.readOffset = (state == MEMREAD) ? counter : physOffset;

  assert property (
    @(posedge clk) disable iff (reset)
    !(way1.writeEn && way2.writeEn)
  ) else $error("iCacheController: both ways written in one cycle");

  assert property (
    @(posedge clk) disable iff (reset)
    !iStall |-> !hRequest
  ) else $error("iCacheController: bus request without stall");

  // Counter moves only on a bus beat or when cleared
  assert property (
    @(posedge clk) disable iff (reset)
    (counterReg != $past(counterReg)) |-> ($past(busReady) || $past(clearCounter))
  ) else $error("iCacheController: counter changed without busReady");

endmodule

// ==== hdl/iCacheTop.sv ====
// ################################################
// Two-way instruction cache top level, front end
// and bus on plain ports
// ################################################

`timescale 1ns/1ps

module iCacheTop #(
  parameter int tagBits = 14,
  parameter int setBits = 4
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          enable,
  input  logic                          paReady,
  input  logic                          busReady,
  input  logic [tagBits+setBits+1:0]    physAddr,
  input  iCachePkg::instrWord           busData,
  output iCachePkg::instrWord           instr,
  output logic                          iStall,
  output logic                          hRequest,
  output logic [tagBits+setBits+1:0]    busAddr
);
  import iCachePkg::*;

  logic [tagBits-1:0] physTag;
  logic [setBits-1:0] setIndex;
  wordOffset          physOffset;
  wordOffset          counter;
  logic               waySel;
  logic               currLru;
  logic               lruUpdate;

  // Address fields, tag | set | word
  assign physTag    = physAddr[tagBits+setBits+1 -: tagBits];
  assign setIndex   = physAddr[setBits+1:2];
  assign physOffset = physAddr[1:0];

  cacheWayIf #(.tagBits(tagBits), .setBits(setBits)) way1Bus ();
  cacheWayIf #(.tagBits(tagBits), .setBits(setBits)) way2Bus ();

  // Both ways see the same set and the same bus beat
  assign way1Bus.setIndex  = setIndex;
  assign way2Bus.setIndex  = setIndex;
  assign way1Bus.writeData = busData;
  assign way2Bus.writeData = busData;

  iCacheController #(.tagBits(tagBits)) controller_i (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .paReady    (paReady),
    .busReady   (busReady),
    .currLru    (currLru),
    .physTag    (physTag),
    .physOffset (physOffset),
    .way1       (way1Bus.ctrl),
    .way2       (way2Bus.ctrl),
    .counter    (counter),
    .waySel     (waySel),
    .iStall     (iStall),
    .hRequest   (hRequest),
    .lruUpdate  (lruUpdate)
  );

  iCacheWay #(.tagBits(tagBits), .setBits(setBits)) way1_i (
    .clk   (clk),
    .reset (reset),
    .bus   (way1Bus.way)
  );

  iCacheWay #(.tagBits(tagBits), .setBits(setBits)) way2_i (
    .clk   (clk),
    .reset (reset),
    .bus   (way2Bus.way)
  );

  // waySel names the hitting way whenever an update fires
  iCacheLru #(.setBits(setBits)) lru_i (
    .clk       (clk),
    .reset     (reset),
    .setIndex  (setIndex),
    .lruUpdate (lruUpdate),
    .usedWay1  (waySel),
    .currLru   (currLru)
  );

  assign instr   = waySel ? way1Bus.readData : way2Bus.readData;
  assign busAddr = {physTag, setIndex, counter};

endmodule

// ==== test/iCacheTb.sv ====
// ################################################
// Trace-driven testbench for the two-way icache
// with a bus memory model and irregular bus gaps
// ################################################

`timescale 1ns/1ps

module iCacheTb;
  import iCachePkg::*;

  localparam int tagBits      = 14;
  localparam int setBits      = 4;
  localparam int addrBits     = tagBits + setBits + 2;
  localparam int fetchTimeout = 40;

  logic                clk;
  logic                reset;
  logic                enable;
  logic                paReady;
  logic                busReady;
  logic [addrBits-1:0] physAddr;
  instrWord            busData;
  instrWord            instr;
  logic                iStall;
  logic                hRequest;
  logic [addrBits-1:0] busAddr;

  // Bus memory filled from the trace
  instrWord memory [logic [addrBits-1:0]];

  // Fetches from the trace in order
  string               fetchName[$];
  logic                fetchEnable[$];
  logic [addrBits-1:0] fetchAddr[$];
  instrWord            fetchInstr[$];
  logic                fetchMiss[$];

  logic [31:0] lfsrState;
  int          testsRun;
  int          testsFailed;
  int          checkErrors;

  iCacheTop #(.tagBits(tagBits), .setBits(setBits)) iCacheTop_i (
    .clk      (clk),
    .reset    (reset),
    .enable   (enable),
    .paReady  (paReady),
    .busReady (busReady),
    .physAddr (physAddr),
    .busData  (busData),
    .instr    (instr),
    .iStall   (iStall),
    .hRequest (hRequest),
    .busAddr  (busAddr)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // Two random bits give an idle gap of 0 to 3 cycles
  task automatic drawGap(output int gap);
    gap = 0;
    for (int i = 0; i < 2; i++) begin
      lfsrState = lfsrNext(lfsrState);
      gap = (gap << 1) | int'(lfsrState[0]);
    end
  endtask

  // Unloaded words still differ across the whole address
  function automatic instrWord readMem(input logic [addrBits-1:0] addr);
    if (memory.exists(addr)) begin
      return memory[addr];
    end
    return {~addr[11:0], addr};
  endfunction

  task automatic loadTrace(output bit ok);
    int          fd;
    int          fields;
    string       line;
    string       kind;
    string       name;
    int          en;
    int          miss;
    logic [31:0] addr;
    logic [31:0] data;
    ok = 1'b1;
    fd = $fopen("test/iCacheTrace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file test/iCacheTrace.txt");
      ok = 1'b0;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      fields = $sscanf(line, "%s", kind);
      if (fields < 1 || kind.getc(0) == "#") begin
        continue;
      end
      if (kind == "M" && $sscanf(line, "%s %h %h", kind, addr, data) == 3) begin
        memory[addr[addrBits-1:0]] = data;
      end else if (kind == "F" &&
                   $sscanf(line, "%s %s %d %h %h %d", kind, name, en, addr, data, miss) == 6) begin
        fetchName.push_back(name);
        fetchEnable.push_back(en != 0);
        fetchAddr.push_back(addr[addrBits-1:0]);
        fetchInstr.push_back(data);
        fetchMiss.push_back(miss != 0);
      end else begin
        $display("Trace line could not be understood: %0s", line);
        ok = 1'b0;
      end
    end
    $fclose(fd);
  endtask

  task automatic compareInstr(input string testName, input instrWord expected,
                              input instrWord actual, inout bit testOk);
    if (actual !== expected) begin
      $display("CHECK FAILED %0s instr expected %h actual %h", testName, expected, actual);
      checkErrors++;
      testOk = 1'b0;
    end
  endtask

  task automatic compareMiss(input string testName, input logic expected,
                             input logic actual, inout bit testOk);
    if (actual !== expected) begin
      $display("CHECK FAILED %0s miss expected %b actual %b", testName, expected, actual);
      checkErrors++;
      testOk = 1'b0;
    end
  endtask

  task automatic compareRequest(input string testName, input logic expected,
                                input logic actual, inout bit testOk);
    if (actual !== expected) begin
      $display("CHECK FAILED %0s hRequest expected %b actual %b", testName, expected, actual);
      checkErrors++;
      testOk = 1'b0;
    end
  endtask

  task automatic compareAddr(input string testName, input logic [addrBits-1:0] expected,
                             input logic [addrBits-1:0] actual, inout bit testOk);
    if (actual !== expected) begin
      $display("CHECK FAILED %0s busAddr expected %h actual %h", testName, expected, actual);
      checkErrors++;
      testOk = 1'b0;
    end
  endtask

  // Present one fetch and hold it until the stall clears
  task automatic runFetch(input int idx, output bit timedOut);
    bit                  testOk;
    logic                missSeen;
    logic                reqSeen;
    logic [addrBits-1:0] addrSeen;
    logic [addrBits-1:0] firstBeat;
    instrWord            got;
    int                  cycles;
    testOk   = 1'b1;
    timedOut = 1'b0;
    cycles   = 0;
    @(negedge clk);
    enable   = fetchEnable[idx];
    physAddr = fetchAddr[idx];
    paReady  = 1'b1;
    @(posedge clk);
    missSeen = iStall;
    reqSeen  = hRequest;
    addrSeen = busAddr;
    got      = instr;
    while (iStall !== 1'b0 && cycles < fetchTimeout) begin
      @(posedge clk);
      cycles++;
      got = instr;
    end
    if (iStall !== 1'b0) begin
      $display("Timeout: fetch %0s still stalled after %0d cycles", fetchName[idx], cycles);
      timedOut = 1'b1;
      testOk   = 1'b0;
    end else begin
      compareMiss(fetchName[idx], fetchMiss[idx], missSeen, testOk);
      compareRequest(fetchName[idx], fetchMiss[idx], reqSeen, testOk);
      if (fetchMiss[idx]) begin
        // Refill starts at word 0 of the line, a single-word fetch at the word itself
        firstBeat = fetchAddr[idx];
        if (fetchEnable[idx]) begin
          firstBeat[1:0] = 2'b00;
        end
        compareAddr(fetchName[idx], firstBeat, addrSeen, testOk);
      end
      compareInstr(fetchName[idx], fetchInstr[idx], got, testOk);
    end
    if (!testOk) begin
      testsFailed++;
    end
    $display("%0s %0s", testOk ? "PASS" : "FAIL", fetchName[idx]);
  endtask

  // Bus model answering each request with busReady pulses after random gaps
  initial begin : busModel
    int gap;
    int beatsLeft;
    bit active;
    bit pulse;
    busReady  = 1'b0;
    busData   = '0;
    lfsrState = 32'hc46;
    gap       = 0;
    beatsLeft = 0;
    active    = 1'b0;
    forever begin
      @(posedge clk);
      pulse = 1'b0;
      if (hRequest !== 1'b1) begin
        active    = 1'b0;
        beatsLeft = 0;
      end else begin
        if (!active) begin
          active    = 1'b1;
          beatsLeft = enable ? LINE_WORDS : 1;
          drawGap(gap);
        end else if (busReady) begin
          beatsLeft--;
          drawGap(gap);
        end else if (gap > 0) begin
          gap--;
        end
        pulse = (beatsLeft > 0) && (gap == 0);
      end
      @(negedge clk);
      busReady = pulse;
      busData  = pulse ? readMem(busAddr) : '0;
    end
  end

  initial begin : mainFlow
    bit traceOk;
    bit timedOut;
    bit aborted;
    reset       = 1'b1;
    enable      = 1'b1;
    paReady     = 1'b0;
    physAddr    = '0;
    testsRun    = 0;
    testsFailed = 0;
    checkErrors = 0;
    aborted     = 1'b0;
    loadTrace(traceOk);
    if (!traceOk || fetchName.size() == 0) begin
      $display("No usable fetches were read from the trace");
      aborted = 1'b1;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < fetchName.size() && !aborted; i++) begin
      runFetch(i, timedOut);
      testsRun++;
      if (timedOut) begin
        aborted = 1'b1;
      end
    end
    @(negedge clk);
    paReady = 1'b0;
    $display("Tests run %0d, tests failed %0d, check errors %0d",
             testsRun, testsFailed, checkErrors);
    if (!aborted && checkErrors == 0 && testsFailed == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== test/iCacheTrace.txt ====
# M <bus address hex> <memory word hex>
# F <test name> <enable> <physical address hex> <expected instr hex> <expected miss>
M 001d4 00500093
M 001d5 00a00113
M 001d6 00f00193
M 001d7 01400213
M 05564 13050513
M 05565 00c58593
M 05566 40b50533
M 05567 00008067
M 0048c 0010a023
M 0048d 0020a223
M 0048e 0030a423
M 0048f 0040a623
M 0294c fe010113
M 0294d 00112e23
M 0294e 00812c23
M 0294f 02010413
M 0f04c 00000297
M 0f04d 01028293
M 0f04e 30529073
M 0f04f 10500073
M 7f3a1 0000006f
# Cold miss, then hits on the rest of the line
F coldMissD1 1 001d5 00a00113 1
F hitD3 1 001d7 01400213 0
F hitD0 1 001d4 00500093 0
F hitD2 1 001d6 00f00193 0
F missE0 1 05564 13050513 1
F hitE1 1 05565 00c58593 0
F hitE2 1 05566 40b50533 0
F hitE3 1 05567 00008067 0
# Set 3 holds two tags, then a third evicts the older one
F fillA0 1 0048c 0010a023 1
F fillB1 1 0294d 00112e23 1
F hitA2 1 0048e 0030a423 0
F hitB3 1 0294f 02010413 0
F hitA1 1 0048d 0020a223 0
F evictC2 1 0f04e 30529073 1
F keepA3 1 0048f 0040a623 0
F refetchB0 1 0294c fe010113 1
F hitA0 1 0048c 0010a023 0
F hitB2 1 0294e 00812c23 0
# Cache off, single-word fetches
F offD2 0 001d6 00f00193 1
F offE1 0 05565 00c58593 1
F offX 0 7f3a1 0000006f 1
F offD2b 0 001d6 00f00193 1

// ==== iCache.f ====
hdl/iCachePkg.sv
hdl/cacheWayIf.sv
hdl/iCacheWay.sv
hdl/iCacheLru.sv
hdl/iCacheController.sv
hdl/iCacheTop.sv
test/iCacheTb.sv

// ==== Bender.yml ====
package:
  name: iCache

sources:
  - files:
      - hdl/iCachePkg.sv
      - hdl/cacheWayIf.sv
      - hdl/iCacheWay.sv
      - hdl/iCacheLru.sv
      - hdl/iCacheController.sv
      - hdl/iCacheTop.sv
  - target: test
    files:
      - test/iCacheTb.sv
